/* rtl/cpu_consts.svh */
// core constants
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// pc value after reset
`define CPU_RESET_PC 32'h0000_0000

// rv32i major opcodes of the supported set
`define CPU_OP_LUI    7'b0110111
`define CPU_OP_JAL    7'b1101111
`define CPU_OP_JALR   7'b1100111
`define CPU_OP_BRANCH 7'b1100011
`define CPU_OP_LOAD   7'b0000011
`define CPU_OP_STORE  7'b0100011
`define CPU_OP_OPIMM  7'b0010011

// architectural registers, x0 included
`define CPU_NREGS 32

`endif

/* rtl/cpu_pkg.sv */
// core types
package cpu_pkg;

	// one instruction word, four ways to slice it
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_view;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_view;
		struct packed {
			logic       imm_20;
			logic [9:0] imm_10_1;
			logic       imm_11;
			logic [7:0] imm_19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_view;
	} instr_t;

	typedef enum logic [1:0] {
		PC_HOLD,
		PC_SEQ,
		PC_TAKEN,
		PC_REG
	} pc_sel_t;

	typedef struct packed {
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic        is_lui;
		logic        is_jal;
		logic        is_jalr;
		logic        is_branch;
		logic        branch_ne;
		logic        is_load;
		logic        is_store;
		logic        reg_write;
	} ctrl_t;

	// wishbone classic, master side
	typedef struct packed {
		logic [31:0] adr;
		logic [31:0] dat_w;
		logic        we;
		logic        cyc;
		logic        stb;
	} wb_req_t;

	// wishbone classic, slave side
	typedef struct packed {
		logic [31:0] dat_r;
		logic        ack;
	} wb_rsp_t;

endpackage

/* rtl/instr_decoder.sv */
// instruction decoder
`include "cpu_consts.svh"

module instr_decoder
	import cpu_pkg::*;
(
	input  instr_t instr,
	output ctrl_t  ctrl
);

	logic writes_rd;

	always_comb begin
		ctrl = '0;
		writes_rd = 1'b0;
		ctrl.rd = instr.r_view.rd;
		ctrl.rs1 = instr.r_view.rs1;
		ctrl.rs2 = instr.r_view.rs2;
		case (instr.r_view.opcode)
			`CPU_OP_LUI: begin
				ctrl.is_lui = 1'b1;
				writes_rd = 1'b1;
				// u-format takes the upper 20 bits of the word
				ctrl.imm = {instr.i_view.imm, instr.i_view.rs1, instr.i_view.funct3, 12'h000};
			end
			`CPU_OP_JAL: begin
				ctrl.is_jal = 1'b1;
				writes_rd = 1'b1;
				ctrl.imm = {{11{instr.j_view.imm_20}}, instr.j_view.imm_20,
					instr.j_view.imm_19_12, instr.j_view.imm_11,
					instr.j_view.imm_10_1, 1'b0};
			end
			`CPU_OP_JALR: begin
				ctrl.is_jalr = 1'b1;
				writes_rd = 1'b1;
				ctrl.imm = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
			end
			`CPU_OP_BRANCH: begin
				ctrl.is_branch = 1'b1;
				// funct3 bit 0 splits beq from bne
				ctrl.branch_ne = instr.r_view.funct3[0];
				// b-format rides on the store split fields
				ctrl.imm = {{19{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi[6],
					instr.s_view.imm_lo[0], instr.s_view.imm_hi[5:0],
					instr.s_view.imm_lo[4:1], 1'b0};
			end
			`CPU_OP_LOAD: begin
				ctrl.is_load = 1'b1;
				writes_rd = 1'b1;
				ctrl.imm = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
			end
			`CPU_OP_STORE: begin
				ctrl.is_store = 1'b1;
				ctrl.imm = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi,
					instr.s_view.imm_lo};
			end
			`CPU_OP_OPIMM: begin
				writes_rd = 1'b1;
				ctrl.imm = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};
			end
			default: begin
				// unknown opcode runs as addi x0, x0, 0
				ctrl.rd = 5'd0;
				ctrl.rs1 = 5'd0;
				ctrl.rs2 = 5'd0;
			end
		endcase
		ctrl.reg_write = writes_rd && (ctrl.rd != 5'd0);
	end

endmodule

/* rtl/next_pc_unit.sv */
// program counter and next pc select
`include "cpu_consts.svh"

module next_pc_unit
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  pc_sel_t     pc_sel,
	input  logic        update,
	input  logic [31:0] imm,
	input  logic [31:0] rs1_val,
	output logic [31:0] pc,
	output logic [31:0] pc_plus4
);

	logic [31:0] pc_q;
	logic [31:0] target;
	logic [31:0] next_pc;

	assign pc_plus4 = pc_q + 32'd4;

	// jal and branches are pc relative, jalr is register relative
	assign target = (pc_sel == PC_REG) ? (rs1_val + imm) : (pc_q + imm);

	always_comb begin
		case (pc_sel)
			PC_SEQ: next_pc = pc_plus4;
			PC_TAKEN,
			PC_REG: next_pc = target;
			default: next_pc = pc_q;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= `CPU_RESET_PC;
		end else if (update) begin
			// fetch addresses are always word aligned
			pc_q <= {next_pc[31:2], 2'b00};
		end
	end

	// also the instruction fetch address
	assign pc = pc_q;

endmodule

/* rtl/wb_classic_master.sv */
// wishbone classic bus master
module wb_classic_master
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  wb_req_t     req_in,
	output logic        done,
	output logic [31:0] rdata,
	output wb_req_t     bus_req,
	input  wb_rsp_t     bus_rsp
);

	// request and wait-ack are one state, stb just stays up until ack
	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_ACK,
		S_FIN
	} state_t;

	state_t      state;
	wb_req_t     req_q;
	logic [31:0] rdata_q;
	logic        active;

	assign active = (state == S_WAIT_ACK);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (start) state <= S_WAIT_ACK;
				S_WAIT_ACK: if (bus_rsp.ack) state <= S_FIN;
				default: state <= S_IDLE;
			endcase
		end
	end

	// payload held for the whole cycle
	always_ff @(posedge clk) begin
		if (start && state == S_IDLE) begin
			req_q <= req_in;
		end
		if (active && bus_rsp.ack) begin
			rdata_q <= bus_rsp.dat_r;
		end
	end

	always_comb begin
		bus_req = req_q;
		bus_req.we = req_q.we & active;
		bus_req.cyc = active;
		bus_req.stb = active;
	end

	// one cycle after ack, bus already released
	assign done = (state == S_FIN);
	assign rdata = rdata_q;

endmodule

/* rtl/reg_file.sv */
// integer register file
`include "cpu_consts.svh"

module reg_file (
	input  logic        clk,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [0:`CPU_NREGS-1];

	// x0 slot is never written
	always_ff @(posedge clk) begin
		if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

/* rtl/core_sequencer.sv */
// instruction phase sequencer
module core_sequencer
	import cpu_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  ctrl_t       ctrl,
	input  logic [31:0] rs1_val,
	input  logic [31:0] rs2_val,
	input  logic [31:0] pc,
	input  logic [31:0] pc_plus4,
	output logic        ifetch_start,
	output logic        dmem_start,
	input  logic        ifetch_done,
	input  logic        dmem_done,
	output wb_req_t     dmem_req,
	input  logic [31:0] dmem_rdata,
	output pc_sel_t     pc_sel,
	output logic        pc_update,
	output logic        rf_we,
	output logic [31:0] rf_wdata
);

	typedef enum logic [1:0] {
		PH_FETCH,
		PH_EXEC,
		PH_MEM,
		PH_WB
	} phase_t;

	phase_t      phase;
	logic        issued;
	logic [31:0] alu_a;
	logic [31:0] sum;
	logic        take;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_FETCH;
			issued <= 1'b0;
		end else begin
			case (phase)
				PH_FETCH: begin
					issued <= !ifetch_done;
					if (ifetch_done) phase <= PH_EXEC;
				end
				PH_EXEC: begin
					if (ctrl.is_load || ctrl.is_store) phase <= PH_MEM;
					else phase <= PH_WB;
				end
				PH_MEM: begin
					issued <= !dmem_done;
					if (dmem_done) phase <= PH_WB;
				end
				default: phase <= PH_FETCH;
			endcase
		end
	end

	// one start pulse per bus phase
	assign ifetch_start = (phase == PH_FETCH) && !issued;
	assign dmem_start = (phase == PH_MEM) && !issued;

	// shared adder, pc relative for jal
	assign alu_a = ctrl.is_jal ? pc : rs1_val;
	assign sum = alu_a + ctrl.imm;

	always_comb begin
		dmem_req.adr = {sum[31:2], 2'b00};
		dmem_req.dat_w = rs2_val;
		dmem_req.we = ctrl.is_store;
		dmem_req.cyc = dmem_start;
		dmem_req.stb = dmem_start;
	end

	// beq when equal, bne when not
	assign take = ctrl.is_branch && ((rs1_val == rs2_val) != ctrl.branch_ne);

	always_comb begin
		if (phase != PH_WB) pc_sel = PC_HOLD;
		else if (ctrl.is_jalr) pc_sel = PC_REG;
		else if (ctrl.is_jal || take) pc_sel = PC_TAKEN;
		else pc_sel = PC_SEQ;
	end

	assign pc_update = (phase == PH_WB);
	assign rf_we = (phase == PH_WB) && ctrl.reg_write;

	always_comb begin
		if (ctrl.is_jal || ctrl.is_jalr) rf_wdata = pc_plus4;
		else if (ctrl.is_lui) rf_wdata = ctrl.imm;
		else if (ctrl.is_load) rf_wdata = dmem_rdata;
		else rf_wdata = sum;
	end

endmodule

/* rtl/fetch_mem_top.sv */
// fetch and memory access front end
module fetch_mem_top
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	output wb_req_t ibus_req,
	input  wb_rsp_t ibus_rsp,
	output wb_req_t dbus_req,
	input  wb_rsp_t dbus_rsp
);

	ctrl_t       ctrl;
	instr_t      instr;
	pc_sel_t     pc_sel;
	wb_req_t     ifetch_req;
	wb_req_t     dmem_req;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] ifetch_rdata;
	logic [31:0] dmem_rdata;
	logic [31:0] rf_wdata;
	logic        ifetch_start;
	logic        ifetch_done;
	logic        dmem_start;
	logic        dmem_done;
	logic        pc_update;
	logic        rf_we;

	// fetched word stays in the ibus master until the next fetch
	assign instr = ifetch_rdata;

	// instruction bus only reads, at the current pc
	assign ifetch_req = '{adr: pc, dat_w: 32'h0, we: 1'b0, cyc: ifetch_start,
		stb: ifetch_start};

	core_sequencer u_seq (
		.clk(clk), .rst(rst), .ctrl(ctrl), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.pc(pc), .pc_plus4(pc_plus4), .ifetch_start(ifetch_start),
		.dmem_start(dmem_start), .ifetch_done(ifetch_done), .dmem_done(dmem_done),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .pc_sel(pc_sel),
		.pc_update(pc_update), .rf_we(rf_we), .rf_wdata(rf_wdata)
	);

	instr_decoder u_dec (
		.instr(instr), .ctrl(ctrl)
	);

	next_pc_unit u_npc (
		.clk(clk), .rst(rst), .pc_sel(pc_sel), .update(pc_update), .imm(ctrl.imm),
		.rs1_val(rs1_val), .pc(pc), .pc_plus4(pc_plus4)
	);

	reg_file u_rf (
		.clk(clk), .raddr1(ctrl.rs1), .raddr2(ctrl.rs2), .rdata1(rs1_val),
		.rdata2(rs2_val), .we(rf_we), .waddr(ctrl.rd), .wdata(rf_wdata)
	);

	wb_classic_master i_ibus (
		.clk(clk), .rst(rst), .start(ifetch_start), .req_in(ifetch_req),
		.done(ifetch_done), .rdata(ifetch_rdata), .bus_req(ibus_req), .bus_rsp(ibus_rsp)
	);

	wb_classic_master i_dbus (
		.clk(clk), .rst(rst), .start(dmem_start), .req_in(dmem_req),
		.done(dmem_done), .rdata(dmem_rdata), .bus_req(dbus_req), .bus_rsp(dbus_rsp)
	);

endmodule

/* tb/clk_gen.sv */
// clock and reset source
module clk_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tb/tb_assertions.sv */
// wishbone handshake assertions
module tb_assertions
	import cpu_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input wb_req_t bus_req,
	input wb_rsp_t bus_rsp
);
	timeunit 1ns;
	timeprecision 100ps;

	a_cyc_is_stb: assert property (@(posedge clk) disable iff (rst)
		bus_req.cyc == bus_req.stb)
		else $error("cyc and stb differ");

	// request held while the slave stalls
	a_req_stable: assert property (@(posedge clk) disable iff (rst)
		bus_req.stb && !bus_rsp.ack |=> bus_req.stb && $stable(bus_req.adr)
			&& $stable(bus_req.dat_w) && $stable(bus_req.we))
		else $error("request changed before ack");

	a_release: assert property (@(posedge clk) disable iff (rst)
		bus_req.stb && bus_rsp.ack |=> !bus_req.cyc && !bus_req.stb)
		else $error("cycle still open after ack");

endmodule

/* tb/tb_monitor.sv */
// reference model and checker
`include "cpu_consts.svh"

module tb_monitor
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  wb_req_t ibus_req,
	input  wb_rsp_t ibus_rsp,
	input  wb_req_t dbus_req,
	input  wb_rsp_t dbus_rsp,
	input  logic    report,
	output logic    report_done,
	output int      retired,
	output int      errors
);
	timeunit 1ns;
	timeprecision 100ps;

	// groups: reset fetch, sequential, control flow, stores, loads, bus order
	int          checks [0:5];
	int          fails [0:5];
	logic [31:0] regs [0:31];
	logic [31:0] exp_pc;
	int          next_group;
	logic        mem_pending;
	logic        mem_we;
	logic [31:0] mem_adr;
	logic [31:0] mem_dat;

	function automatic string group_name(input int g);
		case (g)
			0: return "reset fetch";
			1: return "sequential fetch";
			2: return "control flow";
			3: return "stores";
			4: return "loads";
			default: return "bus ordering";
		endcase
	endfunction

	task automatic check(input int g, input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		checks[g]++;
		if (exp !== act) begin
			fails[g]++;
			errors++;
			$display("Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
		end
	endtask

	task automatic expect_true(input logic ok, input string what);
		checks[5]++;
		if (!ok) begin
			fails[5]++;
			errors++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < `CPU_NREGS; i++) begin
			regs[i] = 32'h0;
		end
		for (int g = 0; g < 6; g++) begin
			checks[g] = 0;
			fails[g] = 0;
		end
		exp_pc = `CPU_RESET_PC;
		next_group = 0;
		mem_pending = 1'b0;
		retired = 0;
		errors = 0;
		report_done = 1'b0;
	endtask

	// one instruction of the isa, straight from the encoding rules
	task automatic execute(input logic [31:0] w);
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] result;
		logic [31:0] next;
		logic        wr;
		rd = w[11:7];
		a = regs[w[19:15]];
		b = regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		next = exp_pc + 32'd4;
		next_group = 1;
		wr = 1'b1;
		result = 32'h0;
		case (w[6:0])
			`CPU_OP_LUI: result = {w[31:12], 12'h000};
			`CPU_OP_JAL: begin
				result = exp_pc + 32'd4;
				next = exp_pc + imm_j;
				next_group = 2;
			end
			`CPU_OP_JALR: begin
				result = exp_pc + 32'd4;
				next = a + imm_i;
				next_group = 2;
			end
			`CPU_OP_BRANCH: begin
				wr = 1'b0;
				next_group = 2;
				// funct3 bit 0 set means bne
				if ((a == b) != w[12]) next = exp_pc + imm_b;
			end
			`CPU_OP_LOAD: begin
				mem_pending = 1'b1;
				mem_we = 1'b0;
				mem_adr = (a + imm_i) & ~32'h3;
				result = mem_adr ^ 32'h5a5a_0f0f;
			end
			`CPU_OP_STORE: begin
				wr = 1'b0;
				mem_pending = 1'b1;
				mem_we = 1'b1;
				mem_adr = (a + imm_s) & ~32'h3;
				mem_dat = b;
			end
			`CPU_OP_OPIMM: result = a + imm_i;
			default: wr = 1'b0;
		endcase
		// rs1 was read above, so jalr with rd equal to rs1 still works
		if (wr && rd != 5'd0) regs[rd] = result;
		exp_pc = next & ~32'h3;
	endtask

	task automatic print_report();
		int total;
		int total_fail;
		total = 0;
		total_fail = 0;
		for (int g = 0; g < 6; g++) begin
			$display("test %s done: %0d checks, %0d errors", group_name(g), checks[g],
				fails[g]);
			total += checks[g];
			total_fail += fails[g];
		end
		$display("%0d instructions retired, %0d checks, %0d errors", retired, total,
			total_fail);
	endtask

	always @(posedge clk) begin
		if (rst) begin
			reset_model();
		end else begin
			expect_true(!ibus_req.we, "instruction bus drove we high");
			expect_true(!(ibus_req.cyc && dbus_req.cyc),
				"data bus cycle open during an instruction fetch");
			if (dbus_req.stb && dbus_rsp.ack) begin
				expect_true(mem_pending, "data bus cycle without a load or store");
				if (mem_pending && mem_we) begin
					check(3, "dbus_req.we", 32'(1'b1), 32'(dbus_req.we));
					check(3, "dbus_req.adr", mem_adr, dbus_req.adr);
					check(3, "dbus_req.dat_w", mem_dat, dbus_req.dat_w);
				end else if (mem_pending) begin
					check(4, "dbus_req.we", 32'(1'b0), 32'(dbus_req.we));
					check(4, "dbus_req.adr", mem_adr, dbus_req.adr);
				end
				mem_pending = 1'b0;
			end
			if (ibus_req.stb && ibus_rsp.ack) begin
				expect_true(!mem_pending, "load or store finished without a data bus cycle");
				mem_pending = 1'b0;
				check(next_group, "ibus_req.adr", exp_pc, ibus_req.adr);
				execute(ibus_rsp.dat_r);
				retired++;
			end
		end
		if (report && !report_done) begin
			print_report();
			report_done = 1'b1;
		end
	end

endmodule

/* tb/tb_top.sv */
// front end testbench top
`include "cpu_consts.svh"

module tb_top
	import cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RUN_LEN = 2000;
	localparam int IMAGE_WORDS = 256;

	logic        clk;
	logic        rst;
	wb_req_t     ibus_req;
	wb_rsp_t     ibus_rsp;
	wb_req_t     dbus_req;
	wb_rsp_t     dbus_rsp;
	logic [31:0] image [0:IMAGE_WORDS-1];
	integer      seed;
	logic [1:0]  iwait;
	logic [1:0]  dwait;
	logic        report;
	logic        report_done;
	int          retired;
	int          errors;

	clk_gen u_clk (
		.clk(clk), .rst(rst)
	);

	fetch_mem_top i_dut (
		.clk(clk), .rst(rst), .ibus_req(ibus_req), .ibus_rsp(ibus_rsp),
		.dbus_req(dbus_req), .dbus_rsp(dbus_rsp)
	);

	tb_monitor u_mon (
		.clk(clk), .rst(rst), .ibus_req(ibus_req), .ibus_rsp(ibus_rsp),
		.dbus_req(dbus_req), .dbus_rsp(dbus_rsp), .report(report),
		.report_done(report_done), .retired(retired), .errors(errors)
	);

	bind wb_classic_master tb_assertions u_handshake (
		.clk(clk), .rst(rst), .bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	// registers limited to x0..x7 so results get reused
	function automatic logic [31:0] random_instr();
		logic [31:0] r;
		logic [31:0] f;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] word;
		r = $random(seed);
		f = $random(seed);
		rd = {2'b00, f[2:0]};
		rs1 = {2'b00, f[5:3]};
		rs2 = {2'b00, f[8:6]};
		case (f[11:9])
			3'd0, 3'd1: word = {r[31:20], rs1, 3'b000, rd, `CPU_OP_OPIMM};
			3'd2: word = {r[31:12], rd, `CPU_OP_LUI};
			3'd3: word = {r[31:12], rd, `CPU_OP_JAL};
			3'd4: word = {r[31:20], rs1, 3'b000, rd, `CPU_OP_JALR};
			3'd5: word = {r[31:25], rs2, rs1, 2'b00, r[0], r[11:7], `CPU_OP_BRANCH};
			3'd6: word = {r[31:20], rs1, 3'b010, rd, `CPU_OP_LOAD};
			default: word = {r[31:25], rs2, rs1, 3'b010, r[11:7], `CPU_OP_STORE};
		endcase
		return word;
	endfunction

	initial begin
		seed = 32'h933a_9296;
		ibus_rsp <= '0;
		dbus_rsp <= '0;
		iwait <= 2'd0;
		dwait <= 2'd0;
		report <= 1'b0;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			image[i] = random_instr();
		end
		// preamble gives x1..x7 known values before any random use
		for (int i = 1; i < 8; i++) begin
			image[i-1] = {image[i-1][31:20], 5'd0, 3'b000, 5'(i), `CPU_OP_OPIMM};
		end
		wait (retired == RUN_LEN);
		@(posedge clk);
		report <= 1'b1;
		wait (report_done);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// both slaves ack after 0 to 3 wait cycles
	always @(posedge clk) begin
		if (rst) begin
			ibus_rsp.ack <= 1'b0;
			dbus_rsp.ack <= 1'b0;
			iwait <= 2'd0;
			dwait <= 2'd0;
		end else begin
			if (ibus_rsp.ack) begin
				ibus_rsp.ack <= 1'b0;
			end else if (ibus_req.stb) begin
				if (iwait == 2'd0) begin
					ibus_rsp.ack <= 1'b1;
					ibus_rsp.dat_r <= image[ibus_req.adr[9:2]];
					iwait <= 2'($random(seed));
				end else begin
					iwait <= iwait - 2'd1;
				end
			end
			if (dbus_rsp.ack) begin
				dbus_rsp.ack <= 1'b0;
			end else if (dbus_req.stb) begin
				if (dwait == 2'd0) begin
					dbus_rsp.ack <= 1'b1;
					dbus_rsp.dat_r <= dbus_req.adr ^ 32'h5a5a_0f0f;
					dwait <= 2'($random(seed));
				end else begin
					dwait <= dwait - 2'd1;
				end
			end
		end
	end

	// worst case instruction takes 16 cycles
	initial begin
		#((RUN_LEN * 16 + 10) * 8);
		$display("watchdog expired with %0d of %0d instructions retired", retired, RUN_LEN);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/next_pc_unit.sv
rtl/wb_classic_master.sv
rtl/reg_file.sv
rtl/core_sequencer.sv
rtl/fetch_mem_top.sv
tb/clk_gen.sv
tb/tb_assertions.sv
tb/tb_monitor.sv
tb/tb_top.sv

/* Makefile */
TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f compile.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -x "Test OK" > /dev/null

clean:
	rm -rf obj_dir
